// ==== dbg_csr.f ====
+incdir+design
design/dbg_pkg.sv
design/dbg_resp_queue.sv
design/dbg_ctrl_regs.sv
design/dbg_hart_slice.sv
design/dbg_status_gather.sv
design/dbg_csr_top.sv
tests/tb_clock_gen.sv
tests/tb_dbg_csr.sv

// ==== design/dbg_csr_top.sv ====
`include "dbg_defines.svh"

module dbg_csr_top import dbg_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dmi_req_valid_i,
  input  dmi_req_t                 dmi_req_i,
  output logic                     dmi_req_ready_o,
  output logic                     dmi_resp_valid_o,
  input  logic                     dmi_resp_ready_i,
  output dmi_resp_t                dmi_resp_o,
  output logic                     ndmreset_o,
  output logic                     dmactive_o,
  input  logic [`DBG_NR_HARTS-1:0] halted_i,
  input  logic [`DBG_NR_HARTS-1:0] unavailable_i,
  input  logic [`DBG_NR_HARTS-1:0] resumeack_i,
  output logic [`DBG_NR_HARTS-1:0] haltreq_o,
  output logic [`DBG_NR_HARTS-1:0] resumereq_o,
  output logic                     clear_resumeack_o,
  output logic                     cmd_valid_o,
  output command_t                 cmd_o,
  input  logic                     cmderror_valid_i,
  input  cmderr_e                  cmderror_i,
  input  logic                     cmdbusy_i,
  output data_words_t              data_o,
  input  data_words_t              data_i,
  input  logic                     data_valid_i
);

  logic        req_accept, resp_pop;
  logic        queue_full, queue_empty;
  logic [31:0] resp_data, haltsum0;
  hart_ctrl_t  hart_ctrl;
  dmstatus_t   dmstatus;
  hart_stat_t [`DBG_NR_HARTS-1:0] hart_stats;

  // DMI handshakes
  assign dmi_req_ready_o  = ~queue_full;
  assign req_accept       = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_resp_valid_o = ~queue_empty;
  assign resp_pop         = dmi_resp_valid_o & dmi_resp_ready_i;
  assign dmi_resp_o.resp  = DMI_RESP_SUCCESS;

  dbg_ctrl_regs u_regs (
    .clk_i, .rst_ni, .dmi_req_i, .req_accept_i(req_accept), .resp_data_o(resp_data),
    .dmstatus_i(dmstatus), .haltsum0_i(haltsum0), .hart_ctrl_o(hart_ctrl),
    .dmactive_o, .ndmreset_o, .clear_resumeack_o, .cmd_valid_o, .cmd_o,
    .cmderror_valid_i, .cmderror_i, .cmdbusy_i, .data_o, .data_i, .data_valid_i
  );

  for (genvar h = 0; h < `DBG_NR_HARTS; h++) begin : g_hart
    dbg_hart_slice #(.HART_INDEX(h)) u_slice (
      .clk_i, .rst_ni, .hart_ctrl_i(hart_ctrl),
      .halted_i(halted_i[h]), .unavailable_i(unavailable_i[h]),
      .resumeack_i(resumeack_i[h]), .haltreq_o(haltreq_o[h]),
      .resumereq_o(resumereq_o[h]), .stat_o(hart_stats[h])
    );
  end

  dbg_status_gather u_gather (
    .hartsel_i(hart_ctrl.hartsel), .stats_i(hart_stats),
    .dmstatus_o(dmstatus), .haltsum0_o(haltsum0)
  );

  dbg_resp_queue u_resp_queue (
    .clk_i, .rst_ni, .push_i(req_accept), .data_i(resp_data), .pop_i(resp_pop),
    .full_o(queue_full), .empty_o(queue_empty), .data_o(dmi_resp_o.data)
  );

endmodule

// ==== design/dbg_ctrl_regs.sv ====
`include "dbg_defines.svh"

module dbg_ctrl_regs import dbg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dmi_req_t    dmi_req_i,
  input  logic        req_accept_i,
  output logic [31:0] resp_data_o,
  input  dmstatus_t   dmstatus_i,
  input  logic [31:0] haltsum0_i,
  output hart_ctrl_t  hart_ctrl_o,
  output logic        dmactive_o,
  output logic        ndmreset_o,
  output logic        clear_resumeack_o,
  output logic        cmd_valid_o,
  output command_t    cmd_o,
  input  logic        cmderror_valid_i,
  input  cmderr_e     cmderror_i,
  input  logic        cmdbusy_i,
  output data_words_t data_o,
  input  data_words_t data_i,
  input  logic        data_valid_i
);

  localparam int unsigned DIDX_W = (`DBG_DATA_COUNT > 1) ? $clog2(`DBG_DATA_COUNT) : 1;
  localparam logic [6:0] DATA_END = `DBG_ADDR_DATA0 + 7'(`DBG_DATA_COUNT - 1);

  dmcontrol_t  dmcontrol_d, dmcontrol_q;
  dmcontrol_t  dmcontrol_rd;
  dmcontrol_t  wr_ctrl;
  abstractcs_t abstractcs;
  abstractcs_t wr_abs;
  cmderr_e     cmderr_d, cmderr_q;
  command_t    command_d, command_q;
  logic        cmd_valid_d, cmd_valid_q;
  data_words_t data_d, data_q;
  logic        is_read, is_write;
  logic [DIDX_W-1:0] data_idx;

  assign is_read  = req_accept_i && (dmi_req_i.op == DMI_READ);
  assign is_write = req_accept_i && (dmi_req_i.op == DMI_WRITE);
  assign data_idx = DIDX_W'(dmi_req_i.addr - `DBG_ADDR_DATA0);
  assign wr_ctrl  = dmcontrol_t'(dmi_req_i.data);
  assign wr_abs   = abstractcs_t'(dmi_req_i.data);

  always_comb begin
    abstractcs           = '0;
    abstractcs.datacount = 4'(`DBG_DATA_COUNT);
    abstractcs.busy      = cmdbusy_i;
    abstractcs.cmderr    = cmderr_q;
    // ackhavereset is write-only
    dmcontrol_rd              = dmcontrol_q;
    dmcontrol_rd.ackhavereset = 1'b0;
  end

  // --------------------------------------------------------------------------
  // read multiplexer on the state before the accepting edge
  // --------------------------------------------------------------------------
  always_comb begin
    resp_data_o = '0;
    if (is_read) begin
      case (dmi_req_i.addr) inside
        [`DBG_ADDR_DATA0:DATA_END]: resp_data_o = data_q[data_idx];
        `DBG_ADDR_DMCONTROL:        resp_data_o = dmcontrol_rd;
        `DBG_ADDR_DMSTATUS:         resp_data_o = dmstatus_i;
        `DBG_ADDR_ABSTRACTCS:       resp_data_o = abstractcs;
        `DBG_ADDR_HALTSUM0:         resp_data_o = haltsum0_i;
        default:                    resp_data_o = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb begin
    dmcontrol_d              = dmcontrol_q;
    dmcontrol_d.ackhavereset = 1'b0;
    cmderr_d                 = cmderr_q;
    command_d                = command_q;
    cmd_valid_d              = 1'b0;
    data_d                   = data_q;

    if (is_write) begin
      case (dmi_req_i.addr) inside
        [`DBG_ADDR_DATA0:DATA_END]: begin
          if (!cmdbusy_i) begin
            data_d[data_idx] = dmi_req_i.data;
          end else if (cmderr_q == CMDERR_NONE) begin
            cmderr_d = CMDERR_BUSY;
          end
        end
        `DBG_ADDR_DMCONTROL: begin
          dmcontrol_d       = wr_ctrl;
          dmcontrol_d.zero3 = 1'b0;
          dmcontrol_d.zero2 = '0;
          dmcontrol_d.zero1 = '0;
        end
        `DBG_ADDR_ABSTRACTCS: begin
          // cmderr is write-1-to-clear
          if (!cmdbusy_i) begin
            cmderr_d = cmderr_e'(cmderr_q & ~wr_abs.cmderr);
          end else if (cmderr_q == CMDERR_NONE) begin
            cmderr_d = CMDERR_BUSY;
          end
        end
        `DBG_ADDR_COMMAND: begin
          if (!cmdbusy_i) begin
            command_d   = command_t'(dmi_req_i.data);
            cmd_valid_d = 1'b1;
          end else if (cmderr_q == CMDERR_NONE) begin
            cmderr_d = CMDERR_BUSY;
          end
        end
        default: ;
      endcase
    end

    // hart side wins over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
    if (dmcontrol_q.resumereq && dmstatus_i.allresumeack) begin
      dmcontrol_d.resumereq = 1'b0;
    end
  end

  assign clear_resumeack_o = dmcontrol_q.dmactive && !dmcontrol_q.resumereq &&
                             dmcontrol_d.resumereq;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      cmderr_q    <= CMDERR_NONE;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else if (!dmcontrol_q.dmactive) begin
      // only dmactive can be written while the module is inactive
      dmcontrol_q <= '{dmactive: dmcontrol_d.dmactive, default: '0};
      cmderr_q    <= CMDERR_NONE;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      data_q      <= data_d;
    end
  end

  assign hart_ctrl_o.hartsel      = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign hart_ctrl_o.haltreq      = dmcontrol_q.haltreq;
  assign hart_ctrl_o.resumereq    = dmcontrol_q.resumereq;
  assign hart_ctrl_o.ndmreset     = dmcontrol_q.ndmreset;
  assign hart_ctrl_o.ackhavereset = dmcontrol_q.ackhavereset;

  assign dmactive_o  = dmcontrol_q.dmactive;
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

  a_cmd_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o) else $error("cmd_valid_o high for two cycles");

endmodule

// ==== design/dbg_defines.svh ====
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// hart and register counts
`define DBG_NR_HARTS    4
`define DBG_HARTSEL_W   20
`define DBG_DATA_COUNT  2
`define DBG_RESP_DEPTH  2
`define DBG_VERSION     2

// DMI register map
`define DBG_ADDR_DATA0       7'h04
`define DBG_ADDR_DMCONTROL   7'h10
`define DBG_ADDR_DMSTATUS    7'h11
`define DBG_ADDR_ABSTRACTCS  7'h16
`define DBG_ADDR_COMMAND     7'h17
`define DBG_ADDR_HALTSUM0    7'h40

`endif

// ==== design/dbg_hart_slice.sv ====
`include "dbg_defines.svh"

module dbg_hart_slice import dbg_pkg::*; #(
  parameter int unsigned HART_INDEX = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  hart_ctrl_t hart_ctrl_i,
  input  logic       halted_i,
  input  logic       unavailable_i,
  input  logic       resumeack_i,
  output logic       haltreq_o,
  output logic       resumereq_o,
  output hart_stat_t stat_o
);

  localparam int unsigned SEL_W = `DBG_HARTSEL_W;

  logic selected;
  logic havereset_q;

  assign selected = (hart_ctrl_i.hartsel == SEL_W'(HART_INDEX));

  // set on ndmreset and cleared by an ack to this hart only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q <= 1'b1;
    end else if (hart_ctrl_i.ndmreset) begin
      havereset_q <= 1'b1;
    end else if (hart_ctrl_i.ackhavereset && selected) begin
      havereset_q <= 1'b0;
    end
  end

  assign haltreq_o   = selected & hart_ctrl_i.haltreq;
  assign resumereq_o = selected & hart_ctrl_i.resumereq;

  // an unavailable hart is neither halted nor running
  assign stat_o.halted    = halted_i & ~unavailable_i;
  assign stat_o.running   = ~halted_i & ~unavailable_i;
  assign stat_o.unavail   = unavailable_i;
  assign stat_o.resumeack = resumeack_i;
  assign stat_o.havereset = havereset_q;

  a_run_state_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(stat_o.halted && stat_o.running)) else $error("hart both halted and running");

endmodule

// ==== design/dbg_pkg.sv ====
`include "dbg_defines.svh"

package dbg_pkg;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  localparam logic [1:0] DMI_RESP_SUCCESS = 2'd0;

  typedef struct packed {
    logic [6:0]  addr;
    dmi_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // debug spec 0.13 bit positions with unused fields as zero
  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       zero3;
    logic       ackhavereset;
    logic [1:0] zero2;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [3:0] zero1;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       confstrptrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef enum logic [2:0] {
    CMDERR_NONE       = 3'd0,
    CMDERR_BUSY       = 3'd1,
    CMDERR_NOTSUP     = 3'd2,
    CMDERR_EXCEPTION  = 3'd3,
    CMDERR_HALTRESUME = 3'd4,
    CMDERR_BUS        = 3'd5,
    CMDERR_OTHER      = 3'd7
  } cmderr_e;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  // broadcast from the register block to every hart slice
  typedef struct packed {
    logic [`DBG_HARTSEL_W-1:0] hartsel;
    logic                      haltreq;
    logic                      resumereq;
    logic                      ndmreset;
    logic                      ackhavereset;
  } hart_ctrl_t;

  typedef struct packed {
    logic halted;
    logic running;
    logic unavail;
    logic resumeack;
    logic havereset;
  } hart_stat_t;

  typedef logic [`DBG_DATA_COUNT-1:0][31:0] data_words_t;

endpackage

// ==== design/dbg_resp_queue.sv ====
`include "dbg_defines.svh"

module dbg_resp_queue (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        push_i,
  input  logic [31:0] data_i,
  input  logic        pop_i,
  output logic        full_o,
  output logic        empty_o,
  output logic [31:0] data_o
);

  localparam int unsigned DEPTH = `DBG_RESP_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0][31:0] mem_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [PTR_W-1:0]       wr_idx;
  logic [PTR_W:0]         count_q;

  // write slot sits count entries past the read pointer
  assign wr_idx  = PTR_W'((32'(rd_ptr_q) + 32'(count_q)) % DEPTH);
  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_idx] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (pop_i) begin
        rd_ptr_q <= (32'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o) else $error("response queue pushed while full");
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o) else $error("response queue popped while empty");

endmodule

// ==== design/dbg_status_gather.sv ====
`include "dbg_defines.svh"

module dbg_status_gather import dbg_pkg::*; (
  input  logic [`DBG_HARTSEL_W-1:0]     hartsel_i,
  input  hart_stat_t [`DBG_NR_HARTS-1:0] stats_i,
  output dmstatus_t                     dmstatus_o,
  output logic [31:0]                   haltsum0_o
);

  localparam int unsigned NR_HARTS = `DBG_NR_HARTS;
  localparam int unsigned SEL_W    = `DBG_HARTSEL_W;
  localparam int unsigned IDX_W    = (NR_HARTS > 1) ? $clog2(NR_HARTS) : 1;

  logic       nonexistent;
  hart_stat_t sel_stat;

  assign nonexistent = (32'(hartsel_i) >= NR_HARTS);
  assign sel_stat    = nonexistent ? '0 : stats_i[hartsel_i[IDX_W-1:0]];

  // no hart array mask, so all and any carry the same value
  always_comb begin
    dmstatus_o                = '0;
    dmstatus_o.version        = 4'(`DBG_VERSION);
    dmstatus_o.authenticated  = 1'b1;
    dmstatus_o.allhavereset   = sel_stat.havereset;
    dmstatus_o.anyhavereset   = sel_stat.havereset;
    dmstatus_o.allresumeack   = sel_stat.resumeack;
    dmstatus_o.anyresumeack   = sel_stat.resumeack;
    dmstatus_o.allnonexistent = nonexistent;
    dmstatus_o.anynonexistent = nonexistent;
    dmstatus_o.allunavail     = sel_stat.unavail;
    dmstatus_o.anyunavail     = sel_stat.unavail;
    dmstatus_o.allrunning     = sel_stat.running;
    dmstatus_o.anyrunning     = sel_stat.running;
    dmstatus_o.allhalted      = sel_stat.halted;
    dmstatus_o.anyhalted      = sel_stat.halted;
  end

  // haltsum0 covers harts 0..31 only
  always_comb begin
    haltsum0_o = '0;
    if (hartsel_i[SEL_W-1:5] == '0) begin
      for (int k = 0; k < NR_HARTS; k++) begin
        haltsum0_o[k] = stats_i[k].halted;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f dbg_csr.f \
  --top-module tb_dbg_csr --Mdir obj_dir -o sim_dbg_csr
./obj_dir/sim_dbg_csr > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int unsigned PERIOD       = 40,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release reset away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tests/tb_dbg_csr.sv ====
`include "dbg_defines.svh"

module tb_dbg_csr import dbg_pkg::*; ();

  localparam int NR = `DBG_NR_HARTS;
  localparam int TEST_CYCLES = 6 * 400;
  localparam int WATCHDOG_T = (TEST_CYCLES + 8) * 40 + 2000;

  logic clk, rst_n;
  logic dmi_req_valid_i, dmi_req_ready_o, dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_req_t dmi_req_i;
  dmi_resp_t dmi_resp_o;
  logic ndmreset_o, dmactive_o, clear_resumeack_o, cmd_valid_o;
  logic [NR-1:0] halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
  command_t cmd_o;
  logic cmderror_valid_i, cmdbusy_i, data_valid_i;
  cmderr_e cmderror_i;
  data_words_t data_o, data_i;

  // reference model of queued response words
  logic [31:0] exp_q[$];
  logic [31:0] exp_head;
  int exp_cnt;
  logic pop_pending, bp_mode;
  logic cmd_allowed, clr_allowed;
  command_t exp_cmd;
  int clr_seen, err_cnt, tests_run, tests_failed;
  logic [NR-1:0] hr;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) u_clk (.clk_o(clk), .rst_no(rst_n));

  dbg_csr_top dut0 (
    .clk_i(clk), .rst_ni(rst_n), .dmi_req_valid_i, .dmi_req_i, .dmi_req_ready_o,
    .dmi_resp_valid_o, .dmi_resp_ready_i, .dmi_resp_o, .ndmreset_o, .dmactive_o,
    .halted_i, .unavailable_i, .resumeack_i, .haltreq_o, .resumereq_o,
    .clear_resumeack_o, .cmd_valid_o, .cmd_o, .cmderror_valid_i, .cmderror_i,
    .cmdbusy_i, .data_o, .data_i, .data_valid_i
  );

  // --------------------------------------------------------------------------
  // checkers
  // --------------------------------------------------------------------------
  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    (dmi_resp_valid_o && dmi_resp_ready_i) |-> dmi_resp_o.data == exp_head)
    else begin
      $display("ERR dmi_resp_o.data got %h expected %h",
               $sampled(dmi_resp_o.data), $sampled(exp_head));
      err_cnt++;
    end
  // DMI success code is 0
  a_resp_code: assert property (@(posedge clk) disable iff (!rst_n)
    dmi_resp_valid_o |-> dmi_resp_o.resp == 2'b00)
    else begin
      $display("ERR dmi_resp_o.resp got %h expected %h",
               $sampled(dmi_resp_o.resp), 2'b00);
      err_cnt++;
    end
  a_resp_extra: assert property (@(posedge clk) disable iff (!rst_n)
    dmi_resp_valid_o |-> exp_cnt > 0)
    else begin
      $display("response valid with no request outstanding");
      err_cnt++;
    end
  a_cmd_word: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid_o |-> cmd_o == exp_cmd)
    else begin
      $display("ERR cmd_o got %h expected %h", $sampled(cmd_o), $sampled(exp_cmd));
      err_cnt++;
    end
  a_cmd_launch: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid_o |-> cmd_allowed)
    else begin
      $display("command launched without an accepted command write");
      err_cnt++;
    end
  a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid_o |=> !cmd_valid_o)
    else begin
      $display("cmd_valid_o stayed high for two cycles");
      err_cnt++;
    end
  a_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    clear_resumeack_o |-> clr_allowed)
    else begin
      $display("clear_resumeack_o pulsed without a resume request");
      err_cnt++;
    end
  a_halt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(haltreq_o) && $onehot0(resumereq_o))
    else begin
      $display("halt or resume request reaches more than one hart");
      err_cnt++;
    end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // response side with optional back-pressure
  always @(negedge clk) begin
    if (bp_mode) begin
      dmi_resp_ready_i = ($urandom_range(0, 2) == 0);
    end else begin
      dmi_resp_ready_i = 1'b1;
    end
    pop_pending = rst_n && dmi_resp_valid_o && dmi_resp_ready_i;
  end

  always @(posedge clk) begin
    if (pop_pending && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
      exp_cnt  = exp_q.size();
    end
  end

  always @(posedge clk) begin
    clr_seen <= clr_seen + int'(clear_resumeack_o);
  end

  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired, DUT stopped responding");
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // DMI access and expected-value helpers
  // --------------------------------------------------------------------------
  task automatic dmi_xfer(input dmi_op_e op, input logic [6:0] addr,
                          input logic [31:0] wdata, input logic [31:0] rexp);
    while (!dmi_req_ready_o) @(negedge clk);
    dmi_req_valid_i = 1'b1;
    dmi_req_i       = '{addr: addr, op: op, data: wdata};
    exp_q.push_back((op == DMI_READ) ? rexp : 32'h0);
    exp_head = exp_q[0];
    exp_cnt  = exp_q.size();
    @(negedge clk);
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata);
    dmi_xfer(DMI_WRITE, addr, wdata, '0);
  endtask

  task automatic dmi_read(input logic [6:0] addr, input logic [31:0] rexp);
    dmi_xfer(DMI_READ, addr, '0, rexp);
  endtask

  function automatic logic [31:0] ctrl_word(logic hreq, logic rreq, logic ack,
                                            logic [19:0] sel, logic ndm, logic act);
    dmcontrol_t c;
    c = '0;
    c.haltreq = hreq;
    c.resumereq = rreq;
    c.ackhavereset = ack;
    c.hartsello = sel[9:0];
    c.hartselhi = sel[19:10];
    c.ndmreset = ndm;
    c.dmactive = act;
    return c;
  endfunction

  function automatic logic [31:0] status_word(logic [19:0] sel);
    dmstatus_t s;
    logic h, u;
    s = '0;
    s.version = 4'(`DBG_VERSION);
    s.authenticated = 1'b1;
    if (sel >= NR) begin
      s.allnonexistent = 1'b1;
      s.anynonexistent = 1'b1;
    end else begin
      h = halted_i[sel];
      u = unavailable_i[sel];
      {s.allhalted, s.anyhalted} = {2{h & ~u}};
      {s.allrunning, s.anyrunning} = {2{~h & ~u}};
      {s.allunavail, s.anyunavail} = {2{u}};
      {s.allresumeack, s.anyresumeack} = {2{resumeack_i[sel]}};
      {s.allhavereset, s.anyhavereset} = {2{hr[sel]}};
    end
    return s;
  endfunction

  function automatic logic [31:0] abs_word(logic busy, cmderr_e err);
    abstractcs_t a;
    a = '0;
    a.datacount = 4'(`DBG_DATA_COUNT);
    a.busy = busy;
    a.cmderr = err;
    return a;
  endfunction

  task automatic end_test(input string name, input int errs_before);
    while (exp_q.size() > 0) @(negedge clk);
    tests_run++;
    if (err_cnt != errs_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  initial begin
    int e, k, j;
    logic [31:0] w, w2;
    data_words_t d;
    void'($urandom(53862));
    dmi_req_valid_i = 0;
    dmi_req_i = '0;
    dmi_resp_ready_i = 1;
    halted_i = '0;
    unavailable_i = '0;
    resumeack_i = '0;
    cmderror_valid_i = 0;
    cmderror_i = CMDERR_NONE;
    cmdbusy_i = 0;
    data_i = '0;
    data_valid_i = 0;
    exp_head = '0;
    exp_cnt = 0;
    pop_pending = 0;
    bp_mode = 0;
    cmd_allowed = 0;
    clr_allowed = 0;
    exp_cmd = '0;
    clr_seen = 0;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    hr = '1;
    wait (rst_n === 1'b1);
    @(negedge clk);

    e = err_cnt;
    check_val("dmi_resp_valid_o", dmi_resp_valid_o, 0);
    check_val("cmd_valid_o", cmd_valid_o, 0);
    check_val("haltreq_o", haltreq_o, 0);
    check_val("resumereq_o", resumereq_o, 0);
    check_val("ndmreset_o", ndmreset_o, 0);
    check_val("dmactive_o", dmactive_o, 0);
    check_val("clear_resumeack_o", clear_resumeack_o, 0);
    check_val("dmi_req_ready_o", dmi_req_ready_o, 1);
    bp_mode = 1;
    for (int i = 0; i < 12; i++) begin
      dmi_read(`DBG_ADDR_DMSTATUS, status_word(0));
      dmi_read(`DBG_ADDR_DMCONTROL, 32'h0);
    end
    end_test("reset_identity", e);
    bp_mode = 0;

    e = err_cnt;
    k = $urandom_range(0, NR - 1);
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(1, 0, 0, k, 0, 0));
    check_val("haltreq_o", haltreq_o, 0);
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, 0, 0, 1));
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(1, 0, 0, k, 0, 1));
    check_val("haltreq_o", haltreq_o, 1 << k);
    dmi_read(`DBG_ADDR_DMCONTROL, ctrl_word(1, 0, 0, k, 0, 1));
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(1, 0, 0, k, 0, 0));
    @(negedge clk);
    check_val("haltreq_o", haltreq_o, 0);
    check_val("dmactive_o", dmactive_o, 0);
    dmi_read(`DBG_ADDR_DMCONTROL, 32'h0);
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, 0, 0, 1));
    end_test("dmactive_halt", e);

    e = err_cnt;
    k = $urandom_range(0, NR - 1);
    j = clr_seen;
    clr_allowed = 1;
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 1, 0, k, 0, 1));
    clr_allowed = 0;
    check_val("clear_resumeack_o pulses", clr_seen - j, 1);
    check_val("resumereq_o", resumereq_o, 1 << k);
    resumeack_i[k] = 1'b1;
    @(negedge clk);
    check_val("resumereq_o", resumereq_o, 0);
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(k));
    end_test("resume", e);
    resumeack_i = '0;

    e = err_cnt;
    k = $urandom_range(0, NR - 1);
    j = (k + 1) % NR;
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 1, k, 0, 1));
    @(negedge clk);
    hr[k] = 1'b0;
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(k));
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, j, 0, 1));
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(j));
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, j, 1, 1));
    check_val("ndmreset_o", ndmreset_o, 1);
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, k, 0, 1));
    hr = '1;
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(k));
    end_test("havereset", e);

    e = err_cnt;
    w = $urandom();
    w2 = ~w;
    exp_cmd = w;
    cmd_allowed = 1;
    dmi_write(`DBG_ADDR_COMMAND, w);
    check_val("cmd_valid_o", cmd_valid_o, 1);
    check_val("cmd_o", cmd_o, w);
    @(negedge clk);
    cmd_allowed = 0;
    cmdbusy_i = 1;
    dmi_write(`DBG_ADDR_COMMAND, w2);
    check_val("cmd_o", cmd_o, w);
    dmi_read(`DBG_ADDR_ABSTRACTCS, abs_word(1, CMDERR_BUSY));
    cmdbusy_i = 0;
    dmi_write(`DBG_ADDR_ABSTRACTCS, abs_word(0, CMDERR_OTHER));
    dmi_read(`DBG_ADDR_ABSTRACTCS, abs_word(0, CMDERR_NONE));
    cmderror_valid_i = 1;
    cmderror_i = CMDERR_EXCEPTION;
    @(negedge clk);
    cmderror_valid_i = 0;
    dmi_read(`DBG_ADDR_ABSTRACTCS, abs_word(0, CMDERR_EXCEPTION));
    dmi_write(`DBG_ADDR_ABSTRACTCS, abs_word(0, CMDERR_OTHER));
    end_test("abstract_command", e);

    e = err_cnt;
    d[0] = $urandom();
    d[1] = $urandom();
    dmi_write(`DBG_ADDR_DATA0, d[0]);
    dmi_write(`DBG_ADDR_DATA0 + 7'd1, d[1]);
    dmi_read(`DBG_ADDR_DATA0, d[0]);
    dmi_read(`DBG_ADDR_DATA0 + 7'd1, d[1]);
    data_i = {$urandom(), $urandom()};
    data_valid_i = 1;
    @(negedge clk);
    data_valid_i = 0;
    check_val("data_o", data_o, data_i);
    dmi_read(`DBG_ADDR_DATA0 + 7'd1, data_i[1]);
    for (int i = 0; i < 8; i++) begin
      halted_i = NR'($urandom());
      unavailable_i = NR'($urandom());
      k = $urandom_range(0, NR - 1);
      dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, k, 0, 1));
      dmi_read(`DBG_ADDR_HALTSUM0, 32'(halted_i & ~unavailable_i));
      dmi_read(`DBG_ADDR_DMSTATUS, status_word(k));
    end
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, NR, 0, 1));
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(NR));
    dmi_read(`DBG_ADDR_HALTSUM0, 32'(halted_i & ~unavailable_i));
    dmi_write(`DBG_ADDR_DMCONTROL, ctrl_word(0, 0, 0, 20'h12345, 0, 1));
    dmi_read(`DBG_ADDR_DMSTATUS, status_word(20'h12345));
    dmi_read(`DBG_ADDR_HALTSUM0, 32'h0);
    end_test("data_summary", e);

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
